// File: fetch_frontend.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pc_control.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/fetch_frontend.sv
verif/tb_fetch_frontend.sv

// File: Makefile
# Verilator simulation of the fetch front end

TOP       ?= tb_fetch_frontend
FILELIST  ?= fetch_frontend.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_fetch_frontend.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_frontend;

    localparam int RESET_CYCLES   = 4;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100 + RESET_CYCLES;

    localparam logic [1:0] KIND_IMM    = 2'd0;
    localparam logic [1:0] KIND_JAL    = 2'd1;
    localparam logic [1:0] KIND_BRANCH = 2'd2;

    logic           clk;
    logic           rst_n;
    logic           id_stall;
    logic           ex_stall;
    logic           ex_cond;
    isa_pkg::word_t imem_data;
    isa_pkg::word_t imem_addr;
    logic           bios_en;
    logic           mem_valid;
    isa_pkg::word_t mem_pc;

    logic [31:0]    lfsr_state = 32'hfacd_f748;
    int             cycle_count = 0;

    isa_pkg::word_t mem_word [0:255];     // Instruction memory contents
    logic [1:0]     mem_kind [0:255];     // What each word was built as
    isa_pkg::word_t mem_off  [0:255];     // Byte offset encoded in the word

    // Reference model state
    isa_pkg::word_t m_pc;
    logic           m_id_valid;
    isa_pkg::word_t m_id_pc;
    logic [7:0]     m_id_idx;
    logic           m_ex_valid;
    isa_pkg::word_t m_ex_pc;
    logic [7:0]     m_ex_idx;
    logic           m_mem_valid;
    logic           m_mem_taken;
    isa_pkg::word_t m_mem_pc;
    isa_pkg::word_t m_mem_tgt;

    fetch_frontend dut0 (
        .clk(clk), .rst_n(rst_n), .id_stall(id_stall), .ex_stall(ex_stall),
        .ex_cond(ex_cond), .imem_data(imem_data), .imem_addr(imem_addr),
        .bios_en(bios_en), .mem_valid(mem_valid), .mem_pc(mem_pc)
    );

    assign imem_data = mem_word[imem_addr[9:2]];  // Combinational read, word indexed

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ##################################################
    // Random source and memory image
    // ##################################################

    // Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit returned
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic fill_memory();
        logic [31:0]    r;
        logic [31:0]    body;
        logic [31:0]    w;
        isa_pkg::word_t off;
        for (int i = 0; i < 256; i++) begin
            r    = take_bits(5);
            body = take_bits(25);
            w    = take_bits(6);
            if (w[5:0] == 6'd0) begin
                w[5:0] = 6'd1;             // A JAL onto itself would never advance
            end
            off = {{24{w[5]}}, w[5:0], 2'b00};  // -128 to +124 bytes
            if (r < 32'd4) begin
                mem_kind[i] = KIND_JAL;
                mem_off[i]  = off;
                mem_word[i] = {off[20], off[10:1], off[11], off[19:12], body[4:0], 7'b1101111};
            end else if (r < 32'd9) begin
                mem_kind[i] = KIND_BRANCH;
                mem_off[i]  = off;
                mem_word[i] = {off[12], off[10:5], body[9:5], body[14:10], body[17:15],
                               off[4:1], off[11], 7'b1100011};
            end else begin
                mem_kind[i] = KIND_IMM;
                mem_off[i]  = '0;
                mem_word[i] = {body[24:0], 7'b0010011};
            end
        end
    endtask

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_addr(input string name, input isa_pkg::word_t expected,
                              input isa_pkg::word_t actual);
        if (actual !== expected) begin
            $display("ERROR [%0s] imem_addr expected %h actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_retire(input string name, input logic exp_valid,
                                input isa_pkg::word_t exp_pc, input logic act_valid,
                                input isa_pkg::word_t act_pc);
        if (act_valid !== exp_valid) begin
            $display("ERROR [%0s] mem_valid expected %b actual %b", name, exp_valid, act_valid);
            report_failure();
        end else if (exp_valid && act_pc !== exp_pc) begin
            $display("ERROR [%0s] mem_pc expected %h actual %h", name, exp_pc, act_pc);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR [%0s] bios_en expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    // ##################################################
    // Reference model
    // ##################################################

    task automatic reset_model();
        m_pc        = `RESET_PC;
        m_id_valid  = 1'b0;
        m_id_pc     = '0;
        m_id_idx    = '0;
        m_ex_valid  = 1'b0;
        m_ex_pc     = '0;
        m_ex_idx    = '0;
        m_mem_valid = 1'b0;
        m_mem_taken = 1'b0;
        m_mem_pc    = '0;
        m_mem_tgt   = '0;
    endtask

    // Called at the falling edge, when this cycle's inputs and outputs are settled
    task automatic compare_and_advance();
        string          name;
        logic           redirect;
        logic           stall;
        logic           jal_go;
        logic           pc_we;
        logic           ex_taken;
        isa_pkg::word_t exp_addr;
        redirect = m_mem_taken;
        stall    = id_stall | ex_stall;
        jal_go   = m_id_valid && (mem_kind[m_id_idx] == KIND_JAL) && !stall && !redirect;
        if (redirect) begin
            exp_addr = m_mem_tgt;
            name     = "taken_branch";
        end else if (jal_go) begin
            exp_addr = m_id_pc + mem_off[m_id_idx];
            name     = "jal";
        end else begin
            exp_addr = m_pc;
            name     = stall ? "stall" : "sequential";
        end
        check_addr(name, exp_addr, imem_addr);
        check_retire(name, m_mem_valid, m_mem_pc, mem_valid, mem_pc);
        check_flag("bios_en", exp_addr[31:28] == `BIOS_NIBBLE, bios_en);

        pc_we    = !stall || redirect;     // A redirect overrides both stalls
        ex_taken = m_ex_valid && (mem_kind[m_ex_idx] == KIND_BRANCH) && ex_cond;

        // Oldest slot first so each one reads its predecessor before it moves
        if (ex_stall || redirect) begin
            m_mem_valid = 1'b0;
            m_mem_taken = 1'b0;
        end else begin
            m_mem_valid = m_ex_valid;
            m_mem_taken = ex_taken;
        end
        if (!ex_stall) begin
            m_mem_pc  = m_ex_pc;
            m_mem_tgt = m_ex_pc + mem_off[m_ex_idx];
        end

        if (redirect) begin
            m_ex_valid = 1'b0;
        end else if (!ex_stall) begin
            m_ex_valid = m_id_valid && !id_stall;
        end
        if (!redirect && !stall) begin
            m_ex_pc  = m_id_pc;
            m_ex_idx = m_id_idx;
        end

        if (redirect) begin
            m_id_valid = 1'b0;
        end else if (pc_we) begin
            m_id_valid = 1'b1;
            m_id_pc    = exp_addr;
            m_id_idx   = exp_addr[9:2];
        end
        if (pc_we) begin
            m_pc = exp_addr + 32'd4;
        end
    endtask

    task automatic drive_random_inputs();
        id_stall <= (take_bits(5) < 32'd3);  // Roughly one cycle in ten
        ex_stall <= (take_bits(5) < 32'd3);
        ex_cond  <= take_bits(1) != 32'd0;
    endtask

    // ##################################################
    // Run control
    // ##################################################

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    initial begin
        id_stall <= 1'b0;
        ex_stall <= 1'b0;
        ex_cond  <= 1'b0;
        rst_n    <= 1'b0;
        fill_memory();
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_addr("reset", `RESET_PC, imem_addr);
        check_retire("reset", 1'b0, '0, mem_valid, mem_pc);
        check_flag("reset", 1'b1, bios_en);
        compare_and_advance();             // Inputs are still quiet in this cycle
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            drive_random_inputs();
            @(negedge clk);
            compare_and_advance();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: source/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           id_stall,
    input  logic           ex_stall,
    input  logic           ex_cond,
    input  isa_pkg::word_t imem_data,
    output isa_pkg::word_t imem_addr,
    output logic           bios_en,
    output logic           mem_valid,
    output isa_pkg::word_t mem_pc
);

    pipe_pkg::pc_src_e pc_src;
    logic              pc_we;
    logic              flush;
    logic              id_valid;
    logic              id_target_taken;
    logic              ex_valid;
    logic              mem_redirect_pc;
    isa_pkg::word_t    id_pc;
    isa_pkg::word_t    id_instr;
    isa_pkg::word_t    id_target;
    isa_pkg::word_t    ex_pc;
    isa_pkg::word_t    ex_instr;
    isa_pkg::word_t    mem_alu;

    // ##################################################
    // Control and stages
    // ##################################################

    pc_control u_pc_control (
        .id_stall(id_stall), .ex_stall(ex_stall), .id_target_taken(id_target_taken),
        .mem_redirect_pc(mem_redirect_pc), .pc_src(pc_src), .pc_we(pc_we), .flush(flush)
    );

    if_stage u_if_stage (
        .clk(clk), .rst_n(rst_n), .pc_src(pc_src), .pc_we(pc_we), .flush(flush),
        .id_target(id_target), .mem_alu(mem_alu), .imem_data(imem_data),
        .imem_addr(imem_addr), .bios_en(bios_en),
        .id_pc(id_pc), .id_instr(id_instr), .id_valid(id_valid)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_n(rst_n), .id_pc(id_pc), .id_instr(id_instr), .id_valid(id_valid),
        .id_stall(id_stall), .ex_stall(ex_stall), .flush(flush),
        .id_target_taken(id_target_taken), .id_target(id_target),
        .ex_pc(ex_pc), .ex_instr(ex_instr), .ex_valid(ex_valid)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_n(rst_n), .ex_pc(ex_pc), .ex_instr(ex_instr), .ex_valid(ex_valid),
        .ex_cond(ex_cond), .ex_stall(ex_stall), .mem_redirect_pc(mem_redirect_pc),
        .mem_alu(mem_alu), .mem_valid(mem_valid), .mem_pc(mem_pc)
    );

endmodule

// File: source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::word_t ex_pc,
    input  isa_pkg::word_t ex_instr,
    input  logic           ex_valid,
    input  logic           ex_cond,
    input  logic           ex_stall,
    output logic           mem_redirect_pc,
    output isa_pkg::word_t mem_alu,
    output logic           mem_valid,
    output isa_pkg::word_t mem_pc
);

    isa_pkg::instr_u instr;
    isa_pkg::word_t  b_imm;
    logic            is_branch;
    logic            ex_taken;
    logic            mem_taken;

    // ##################################################
    // Branch target
    // ##################################################

    assign instr     = ex_instr;
    assign is_branch = (instr.b.opcode == isa_pkg::OP_BRANCH);

    assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};

    assign ex_taken = ex_valid & is_branch & ex_cond;  // Condition sampled while in EX

    // ##################################################
    // MEM slot
    // ##################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_taken <= 1'b0;
        end else if (ex_stall || mem_redirect_pc) begin
            mem_valid <= 1'b0;          // Stall bubble, or the entry behind a taken branch
            mem_taken <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
            mem_taken <= ex_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_stall) begin
            mem_pc  <= ex_pc;
            mem_alu <= ex_pc + b_imm;
        end
    end

    assign mem_redirect_pc = mem_taken;

    redirect_target_known: assert property (
        @(posedge clk) disable iff (!rst_n) mem_redirect_pc |-> !$isunknown(mem_alu)
    ) else $error("ex_stage: redirect raised towards an unknown target");

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::word_t id_pc,
    input  isa_pkg::word_t id_instr,
    input  logic           id_valid,
    input  logic           id_stall,
    input  logic           ex_stall,
    input  logic           flush,
    output logic           id_target_taken,
    output isa_pkg::word_t id_target,
    output isa_pkg::word_t ex_pc,
    output isa_pkg::word_t ex_instr,
    output logic           ex_valid
);

    isa_pkg::instr_u instr;
    isa_pkg::word_t  j_imm;
    logic            is_jal;
    logic            ex_load;

    // ##################################################
    // JAL resolution
    // ##################################################

    assign instr  = id_instr;
    assign is_jal = (instr.j.opcode == isa_pkg::OP_JAL);

    assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    assign id_target = id_pc + j_imm;

    // Only a JAL that is really leaving decode this cycle may steer fetch
    assign id_target_taken = id_valid & is_jal & ~id_stall & ~ex_stall & ~flush;

    // ##################################################
    // ID/EX register
    // ##################################################

    assign ex_load = ~flush & ~ex_stall & ~id_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;           // Younger than the taken branch
        end else if (!ex_stall) begin
            ex_valid <= id_valid & ~id_stall;  // Decode stall sends a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (ex_load) begin
            ex_pc    <= id_pc;
            ex_instr <= id_instr;
        end
    end

    // After a JAL fires, fetch has moved on, so decode must see a new PC
    jal_pulse_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        id_target_taken |=> !(id_target_taken && $stable(id_pc))
    ) else $error("id_stage: JAL taken twice for the same PC");

endmodule

// File: source/if_stage.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module if_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::pc_src_e pc_src,
    input  logic              pc_we,
    input  logic              flush,
    input  isa_pkg::word_t    id_target,
    input  isa_pkg::word_t    mem_alu,
    input  isa_pkg::word_t    imem_data,
    output isa_pkg::word_t    imem_addr,
    output logic              bios_en,
    output isa_pkg::word_t    id_pc,
    output isa_pkg::word_t    id_instr,
    output logic              id_valid
);

    isa_pkg::word_t pc_q;               // Next sequential fetch address
    logic           if_load;

    // ##################################################
    // Fetch address override and PC register
    // ##################################################

    always_comb begin
        case (pc_src)
            pipe_pkg::PC_ALU: imem_addr = mem_alu;
            pipe_pkg::PC_TGT: imem_addr = id_target;
            default:          imem_addr = pc_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (pc_we) begin
            pc_q <= imem_addr + 32'd4;  // Continue after whatever was fetched
        end
    end

    assign bios_en = (imem_addr[`XLEN-1 -: 4] == `BIOS_NIBBLE);

    // ##################################################
    // IF/ID register
    // ##################################################

    assign if_load = pc_we & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;           // Redirect empties decode
        end else if (pc_we) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (if_load) begin
            id_pc    <= imem_addr;
            id_instr <= imem_data;
        end
    end

    first_fetch_at_reset_pc: assert property (
        @(posedge clk) $rose(rst_n) |-> (imem_addr == `RESET_PC)
    ) else $error("if_stage: first fetch address is not the reset PC");

endmodule

// File: source/pc_control.sv
`timescale 1ns/1ps

module pc_control (
    input  logic              id_stall,
    input  logic              ex_stall,
    input  logic              id_target_taken,
    input  logic              mem_redirect_pc,
    output pipe_pkg::pc_src_e pc_src,
    output logic              pc_we,
    output logic              flush
);

    logic stall;

    assign stall = id_stall | ex_stall;    // Either stage holding freezes fetch

    // ##################################################
    // Source priority
    // ##################################################

    always_comb begin
        if (mem_redirect_pc) begin
            pc_src = pipe_pkg::PC_ALU;     // Oldest instruction decides first
        end else if (id_target_taken) begin
            pc_src = pipe_pkg::PC_TGT;
        end else begin
            pc_src = pipe_pkg::PC_SEQ;
        end
    end

    // A redirect has to land even while a younger stage is stalled
    assign pc_we = ~stall | mem_redirect_pc;

    assign flush = mem_redirect_pc;        // Kills the entries behind the branch

    // The JAL gating lives in the decode stage; a stalled JAL must not steer fetch
    always_comb begin
        assert final (!(stall && pc_src == pipe_pkg::PC_TGT))
            else $error("pc_control: JAL target selected during a stall");
    end

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    // ##################################################
    // Fetch address source
    // ##################################################

    // The redirect from MEM wins over the JAL target from ID,
    // and both win over the sequential PC
    typedef enum logic [1:0] {
        PC_SEQ = 2'd0,                  // PC register, already advanced by 4
        PC_TGT = 2'd1,                  // JAL target resolved in ID
        PC_ALU = 2'd2                   // Taken branch target from the MEM slot
    } pc_src_e;

endpackage

// File: source/isa_pkg.sv
`include "fetch_defs.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] word_t;  // PC, address and raw instruction

    // Only the opcodes the front end has to tell apart
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,         // Plain ALU op, passes straight through
        OP_BRANCH = 7'b1100011,         // B-type, resolved in EX
        OP_JAL    = 7'b1101111          // J-type, resolved in ID
    } opcode_e;

    // ##################################################
    // Immediate layouts sharing one word
    // ##################################################

    typedef struct packed {
        logic       imm20;              // Sign bit of the J immediate
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fields_t;

    typedef struct packed {
        logic       imm12;              // Sign bit of the B immediate
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fields_t;

    typedef union packed {
        word_t     raw;                 // Word as it comes from memory
        j_fields_t j;                   // Seen by the decode stage
        b_fields_t b;                   // Seen by the execute stage
    } instr_u;

endpackage

// File: source/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ##################################################
// Front end sizing and address map
// ##################################################

`define XLEN        32              // Address and instruction word width

`define RESET_PC    32'h4000_0000   // First fetch address out of reset

`define BIOS_NIBBLE 4'h4            // Top address nibble of the BIOS region

`endif
